// ==== design/zynq_shell_defs.svh ====
`ifndef ZYNQ_SHELL_DEFS_SVH
`define ZYNQ_SHELL_DEFS_SVH

// bus widths, host CSR port uses a narrow address
`define SHELL_ADDR_W          32
`define SHELL_DATA_W          32
`define SHELL_CSR_ADDR_W      6

// core I/O accesses below this address go to the mailbox
`define SHELL_SPLIT_ADDR      32'h0020_0000
// the core sees its DRAM starting here
`define SHELL_CORE_DRAM_BASE  32'h8000_0000

// profiler covers 1 GB of core DRAM in 8 MB regions
`define SHELL_PROFILE_REGIONS 128
`define SHELL_PROFILE_LSB     23

`define SHELL_MAILBOX_DEPTH   4

// host CSR offsets, the profiler words follow PROFILE0 at a step of 4
`define CSR_RUN               6'h00
`define CSR_ALLOC             6'h04
`define CSR_DRAM_BASE         6'h08
`define CSR_MBOX_DATA         6'h10
`define CSR_MBOX_COUNT        6'h14
`define CSR_PROFILE0          6'h20

`endif

// ==== design/zynq_shell_pkg.sv ====
`default_nettype none

`include "zynq_shell_defs.svh"

package zynq_shell_pkg;

   // address on the core I/O, external and DRAM buses
   typedef logic [`SHELL_ADDR_W-1:0] shell_addr_t;

   // one APB data word, which is also one mailbox entry
   typedef logic [`SHELL_DATA_W-1:0] shell_data_t;

   // one bit for every 8 MB region of core DRAM
   typedef logic [`SHELL_PROFILE_REGIONS-1:0] profile_map_t;

endpackage

`default_nettype wire

// ==== design/shell_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

module shell_csr
   import zynq_shell_pkg::*;
(
   input  logic                         aclk_i,
   input  logic                         rst_n_i,
   input  logic                         host_psel_i,
   input  logic                         host_penable_i,
   input  logic                         host_pwrite_i,
   input  logic [`SHELL_CSR_ADDR_W-1:0] host_paddr_i,
   input  shell_data_t                  host_pwdata_i,
   output shell_data_t                  host_prdata_o,
   output logic                         host_pready_o,
   output logic                         host_pslverr_o,
   input  shell_data_t                  mbox_count_i,
   input  shell_data_t                  mbox_data_i,
   input  profile_map_t                 profile_map_i,
   output logic                         run_o,
   output shell_data_t                  dram_base_o,
   output logic                         mbox_pop_o
);

   logic        access;
   logic        mbox_empty;
   logic        decode_err;
   logic        run_q;
   logic        alloc_q;
   shell_data_t base_q;
   shell_data_t rdata;

   // every access phase completes, so a transfer is setup plus one cycle
   assign access = host_psel_i & host_penable_i;
   assign mbox_empty = (mbox_count_i == '0);

   always_comb
   begin
      rdata = '0;
      decode_err = 1'b0;
      case (host_paddr_i)
         `CSR_RUN:       rdata = shell_data_t'(run_q);
         `CSR_ALLOC:     rdata = shell_data_t'(alloc_q);
         `CSR_DRAM_BASE: rdata = base_q;
         `CSR_MBOX_DATA:
         begin
            // popping an empty mailbox returns 0 and an error
            rdata = mbox_empty ? '0 : mbox_data_i;
            decode_err = host_pwrite_i | mbox_empty;
         end
         `CSR_MBOX_COUNT:
         begin
            rdata = mbox_count_i;
            decode_err = host_pwrite_i;
         end
         `CSR_PROFILE0, `CSR_PROFILE0 + 6'h04, `CSR_PROFILE0 + 6'h08, `CSR_PROFILE0 + 6'h0c:
         begin
            // address bits 3:2 pick the profiler word, lowest regions first
            rdata = profile_map_i[host_paddr_i[3:2]*`SHELL_DATA_W +: `SHELL_DATA_W];
            decode_err = host_pwrite_i;
         end
         default:        decode_err = 1'b1;
      endcase
   end

   assign host_prdata_o = rdata;
   assign host_pready_o = access;
   assign host_pslverr_o = access & decode_err;
   assign mbox_pop_o = access & ~host_pwrite_i & ~mbox_empty &
                       (host_paddr_i == `CSR_MBOX_DATA);
   assign run_o = run_q;
   assign dram_base_o = base_q;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         run_q <= 1'b0;
         alloc_q <= 1'b0;
         base_q <= '0;
      end
      else if (access && host_pwrite_i && !decode_err)
      begin
         case (host_paddr_i)
            `CSR_RUN:       run_q <= host_pwdata_i[0];
            `CSR_ALLOC:     alloc_q <= host_pwdata_i[0];
            `CSR_DRAM_BASE: base_q <= host_pwdata_i;
            default:        ;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== design/mailbox_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module mailbox_fifo
   import zynq_shell_pkg::*;
#(
   parameter int depth_p = 4
)
(
   input  logic        aclk_i,
   input  logic        rst_n_i,
   input  logic        push_i,
   input  shell_data_t push_data_i,
   input  logic        pop_i,
   output shell_data_t head_data_o,
   output shell_data_t count_o,
   output logic        full_o
);

   localparam int ptr_w_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int cnt_w_lp = $clog2(depth_p + 1);

   shell_data_t         mem_q [depth_p];
   logic [ptr_w_lp-1:0] wr_ptr_q;
   logic [ptr_w_lp-1:0] rd_ptr_q;
   logic [cnt_w_lp-1:0] count_q;
   logic                do_push;
   logic                do_pop;

   // pointers wrap at the depth, which need not be a power of two
   function automatic logic [ptr_w_lp-1:0] next_ptr(input logic [ptr_w_lp-1:0] ptr);
      return (ptr == ptr_w_lp'(depth_p - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full_o = (count_q == cnt_w_lp'(depth_p));
   assign do_push = push_i & ~full_o;
   assign do_pop = pop_i & (count_q != '0);
   assign head_data_o = mem_q[rd_ptr_q];
   assign count_o = shell_data_t'(count_q);

   always_ff @(posedge aclk_i)
   begin
      if (do_push)
      begin
         mem_q[wr_ptr_q] <= push_data_i;
      end
   end

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (do_pop)
         begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         if (do_push && !do_pop)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (do_pop && !do_push)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/mailbox_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module mailbox_port
   import zynq_shell_pkg::*;
(
   input  logic        aclk_i,
   input  logic        rst_n_i,
   input  logic        psel_i,
   input  logic        penable_i,
   input  logic        pwrite_i,
   input  shell_data_t pwdata_i,
   input  logic        full_i,
   output shell_data_t prdata_o,
   output logic        pready_o,
   output logic        pslverr_o,
   output logic        push_o,
   output shell_data_t push_data_o
);

   // set by a setup phase, so a penable that did not follow one is ignored
   logic setup_q;
   logic access;

   assign access = psel_i & penable_i & setup_q;

   // writes wait for a free entry, reads have no FIFO behind them and fail at once
   assign pready_o = access & ~(pwrite_i & full_i);
   assign pslverr_o = access & ~pwrite_i;
   assign prdata_o = '0;
   assign push_o = access & pwrite_i & ~full_i;
   assign push_data_o = pwdata_i;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         setup_q <= 1'b0;
      end
      else if (psel_i && !penable_i)
      begin
         setup_q <= 1'b1;
      end
      else if (pready_o || !psel_i)
      begin
         setup_q <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// ==== design/core_io_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

module core_io_router
   import zynq_shell_pkg::*;
(
   input  logic        core_io_psel_i,
   input  logic        core_io_penable_i,
   input  logic        core_io_pwrite_i,
   input  shell_addr_t core_io_paddr_i,
   input  shell_data_t core_io_pwdata_i,
   output shell_data_t core_io_prdata_o,
   output logic        core_io_pready_o,
   output logic        core_io_pslverr_o,
   output logic        ext_psel_o,
   output logic        ext_penable_o,
   output logic        ext_pwrite_o,
   output shell_addr_t ext_paddr_o,
   output shell_data_t ext_pwdata_o,
   input  shell_data_t ext_prdata_i,
   input  logic        ext_pready_i,
   input  logic        ext_pslverr_i,
   output logic        mbox_psel_o,
   output logic        mbox_penable_o,
   output logic        mbox_pwrite_o,
   output shell_data_t mbox_pwdata_o,
   input  shell_data_t mbox_prdata_i,
   input  logic        mbox_pready_i,
   input  logic        mbox_pslverr_i
);

   logic to_ext;

   // the address is held for the whole transfer, so the choice is stable too
   assign to_ext = (core_io_paddr_i >= `SHELL_SPLIT_ADDR);

   assign ext_psel_o = core_io_psel_i & to_ext;
   assign ext_penable_o = core_io_penable_i & to_ext;
   assign ext_pwrite_o = core_io_pwrite_i;
   assign ext_paddr_o = core_io_paddr_i;
   assign ext_pwdata_o = core_io_pwdata_i;

   assign mbox_psel_o = core_io_psel_i & ~to_ext;
   assign mbox_penable_o = core_io_penable_i & ~to_ext;
   assign mbox_pwrite_o = core_io_pwrite_i;
   assign mbox_pwdata_o = core_io_pwdata_i;

   assign core_io_prdata_o = to_ext ? ext_prdata_i : mbox_prdata_i;
   assign core_io_pready_o = to_ext ? ext_pready_i : mbox_pready_i;
   assign core_io_pslverr_o = to_ext ? ext_pslverr_i : mbox_pslverr_i;

endmodule

`default_nettype wire

// ==== design/dram_remap.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

module dram_remap
   import zynq_shell_pkg::*;
(
   input  logic         aclk_i,
   input  logic         rst_n_i,
   input  logic         core_rst_n_i,
   input  shell_data_t  dram_base_i,
   input  logic         core_dram_psel_i,
   input  logic         core_dram_penable_i,
   input  logic         core_dram_pwrite_i,
   input  shell_addr_t  core_dram_paddr_i,
   input  shell_data_t  core_dram_pwdata_i,
   output shell_data_t  core_dram_prdata_o,
   output logic         core_dram_pready_o,
   output logic         core_dram_pslverr_o,
   output logic         dram_psel_o,
   output logic         dram_penable_o,
   output logic         dram_pwrite_o,
   output shell_addr_t  dram_paddr_o,
   output shell_data_t  dram_pwdata_o,
   input  shell_data_t  dram_prdata_i,
   input  logic         dram_pready_i,
   input  logic         dram_pslverr_i,
   output profile_map_t profile_map_o
);

   localparam int idx_w_lp = $clog2(`SHELL_PROFILE_REGIONS);

   profile_map_t        map_q;
   logic [idx_w_lp-1:0] region;

   // strip the core DRAM base and move into the buffer the host allocated
   assign dram_paddr_o = (core_dram_paddr_i ^ `SHELL_CORE_DRAM_BASE) + dram_base_i;
   assign dram_psel_o = core_dram_psel_i;
   assign dram_penable_o = core_dram_penable_i;
   assign dram_pwrite_o = core_dram_pwrite_i;
   assign dram_pwdata_o = core_dram_pwdata_i;
   assign core_dram_prdata_o = dram_prdata_i;
   assign core_dram_pready_o = dram_pready_i;
   assign core_dram_pslverr_o = dram_pslverr_i;

   // bit 31 is the base bit removed above, so bits 29:23 name the region
   assign region = core_dram_paddr_i[`SHELL_PROFILE_LSB +: idx_w_lp];
   assign profile_map_o = map_q;

   always_ff @(posedge aclk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         map_q <= '0;
      end
      else if (!core_rst_n_i)
      begin
         map_q <= '0;
      end
      else if (core_dram_psel_i && !core_dram_penable_i)
      begin
         map_q[region] <= 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== design/zynq_shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

module zynq_shell_top
   import zynq_shell_pkg::*;
(
   input  logic                         aclk_i,
   input  logic                         rst_n_i,
   input  logic                         host_psel_i,
   input  logic                         host_penable_i,
   input  logic                         host_pwrite_i,
   input  logic [`SHELL_CSR_ADDR_W-1:0] host_paddr_i,
   input  shell_data_t                  host_pwdata_i,
   output shell_data_t                  host_prdata_o,
   output logic                         host_pready_o,
   output logic                         host_pslverr_o,
   input  logic                         core_io_psel_i,
   input  logic                         core_io_penable_i,
   input  logic                         core_io_pwrite_i,
   input  shell_addr_t                  core_io_paddr_i,
   input  shell_data_t                  core_io_pwdata_i,
   output shell_data_t                  core_io_prdata_o,
   output logic                         core_io_pready_o,
   output logic                         core_io_pslverr_o,
   output logic                         ext_psel_o,
   output logic                         ext_penable_o,
   output logic                         ext_pwrite_o,
   output shell_addr_t                  ext_paddr_o,
   output shell_data_t                  ext_pwdata_o,
   input  shell_data_t                  ext_prdata_i,
   input  logic                         ext_pready_i,
   input  logic                         ext_pslverr_i,
   input  logic                         core_dram_psel_i,
   input  logic                         core_dram_penable_i,
   input  logic                         core_dram_pwrite_i,
   input  shell_addr_t                  core_dram_paddr_i,
   input  shell_data_t                  core_dram_pwdata_i,
   output shell_data_t                  core_dram_prdata_o,
   output logic                         core_dram_pready_o,
   output logic                         core_dram_pslverr_o,
   output logic                         dram_psel_o,
   output logic                         dram_penable_o,
   output logic                         dram_pwrite_o,
   output shell_addr_t                  dram_paddr_o,
   output shell_data_t                  dram_pwdata_o,
   input  shell_data_t                  dram_prdata_i,
   input  logic                         dram_pready_i,
   input  logic                         dram_pslverr_i,
   output logic                         core_rst_n_o
);

   logic         run;
   shell_data_t  dram_base;
   profile_map_t profile_map;
   logic         mbox_psel;
   logic         mbox_penable;
   logic         mbox_pwrite;
   shell_data_t  mbox_pwdata;
   shell_data_t  mbox_prdata;
   logic         mbox_pready;
   logic         mbox_pslverr;
   logic         fifo_push;
   shell_data_t  fifo_push_data;
   logic         fifo_pop;
   shell_data_t  fifo_head;
   shell_data_t  fifo_count;
   logic         fifo_full;

   // the core stays in reset until the host sets run, so a new program can
   // be started without reloading the FPGA
   assign core_rst_n_o = rst_n_i & run;

   shell_csr u_shell_csr (
      .*,
      .mbox_count_i(fifo_count), .mbox_data_i(fifo_head), .profile_map_i(profile_map),
      .run_o(run), .dram_base_o(dram_base), .mbox_pop_o(fifo_pop)
   );

   core_io_router u_core_io_router (
      .*,
      .mbox_psel_o(mbox_psel), .mbox_penable_o(mbox_penable),
      .mbox_pwrite_o(mbox_pwrite), .mbox_pwdata_o(mbox_pwdata),
      .mbox_prdata_i(mbox_prdata), .mbox_pready_i(mbox_pready),
      .mbox_pslverr_i(mbox_pslverr)
   );

   mailbox_port u_mailbox_port (
      .aclk_i(aclk_i), .rst_n_i(rst_n_i),
      .psel_i(mbox_psel), .penable_i(mbox_penable), .pwrite_i(mbox_pwrite),
      .pwdata_i(mbox_pwdata), .full_i(fifo_full),
      .prdata_o(mbox_prdata), .pready_o(mbox_pready), .pslverr_o(mbox_pslverr),
      .push_o(fifo_push), .push_data_o(fifo_push_data)
   );

   mailbox_fifo #(.depth_p(`SHELL_MAILBOX_DEPTH)) u_mailbox_fifo (
      .aclk_i(aclk_i), .rst_n_i(rst_n_i),
      .push_i(fifo_push), .push_data_i(fifo_push_data), .pop_i(fifo_pop),
      .head_data_o(fifo_head), .count_o(fifo_count), .full_o(fifo_full)
   );

   dram_remap u_dram_remap (
      .*,
      .core_rst_n_i(core_rst_n_o), .dram_base_i(dram_base), .profile_map_o(profile_map)
   );

endmodule

`default_nettype wire

// ==== tb/zynq_shell_props.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

// rules that hold on all five top-level APB buses, concatenated with the
// host bus at index 4 down to the host DRAM bus at index 0
module zynq_shell_props
(
   input logic             aclk_i,
   input logic             rst_n_i,
   input logic             core_rst_n_i,
   input logic [4:0]       psel_i,
   input logic [4:0]       penable_i,
   input logic [4:0]       pready_i,
   // pwrite, paddr and pwdata of each bus
   input logic [4:0][64:0] ctl_i
);

   int assert_fails = 0;

   for (genvar b = 0; b < 5; b++)
   begin : g_bus
      // a transfer that has not completed keeps its select, address and data
      held_until_ready: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
         psel_i[b] && !pready_i[b] |=> psel_i[b] && $stable(ctl_i[b]))
      else
      begin
         $error("bus %0d changed its transfer before pready", b);
         assert_fails++;
      end

      enable_needs_select: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
         !(penable_i[b] && !psel_i[b]))
      else
      begin
         $error("bus %0d has penable high without psel", b);
         assert_fails++;
      end
   end

   // the core leaves reset only on the edge after a host write of 1 to the run bit
   core_released_by_run: assert property (@(posedge aclk_i)
      $rose(core_rst_n_i) |-> $past(psel_i[4] && penable_i[4] && pready_i[4] &&
         ctl_i[4][64] && ctl_i[4][37:32] == `CSR_RUN && ctl_i[4][0]))
   else
   begin
      $error("core reset released without a host write of 1 to the run bit");
      assert_fails++;
   end

endmodule

`default_nettype wire

// ==== tb/zynq_shell_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "zynq_shell_defs.svh"

module zynq_shell_tb
   import zynq_shell_pkg::*;
();

   localparam int host_bus_lp = 0;
   localparam int io_bus_lp = 1;
   localparam int dram_bus_lp = 2;
   localparam int ext_port_lp = 0;
   localparam int mem_port_lp = 1;
   localparam int timeout_lp = 64;

   logic aclk;
   logic rst_n;

   // master side, one entry per bus: host, core I/O, core DRAM
   logic [2:0]       m_psel;
   logic [2:0]       m_penable;
   logic [2:0]       m_pwrite;
   logic [2:0][31:0] m_paddr;
   logic [2:0][31:0] m_pwdata;
   wire  [2:0][31:0] s_prdata;
   wire  [2:0]       s_pready;
   wire  [2:0]       s_pslverr;

   // responder side, ext first and then host DRAM
   wire  [1:0]       r_psel;
   wire  [1:0]       r_penable;
   wire  [1:0]       r_pwrite;
   wire  [1:0][31:0] r_paddr;
   wire  [1:0][31:0] r_pwdata;
   logic [1:0][31:0] r_prdata;
   logic [1:0]       r_pready;
   logic [1:0]       r_pslverr;
   wire              core_rst_n;

   logic [31:0] lfsr_state;
   shell_data_t cur_base;
   int          errors;
   int          checks;

   zynq_shell_top u_zynq_shell_top (
      .aclk_i(aclk), .rst_n_i(rst_n),
      .host_psel_i(m_psel[0]), .host_penable_i(m_penable[0]), .host_pwrite_i(m_pwrite[0]),
      .host_paddr_i(m_paddr[0][5:0]), .host_pwdata_i(m_pwdata[0]),
      .host_prdata_o(s_prdata[0]), .host_pready_o(s_pready[0]), .host_pslverr_o(s_pslverr[0]),
      .core_io_psel_i(m_psel[1]), .core_io_penable_i(m_penable[1]),
      .core_io_pwrite_i(m_pwrite[1]), .core_io_paddr_i(m_paddr[1]),
      .core_io_pwdata_i(m_pwdata[1]), .core_io_prdata_o(s_prdata[1]),
      .core_io_pready_o(s_pready[1]), .core_io_pslverr_o(s_pslverr[1]),
      .ext_psel_o(r_psel[0]), .ext_penable_o(r_penable[0]), .ext_pwrite_o(r_pwrite[0]),
      .ext_paddr_o(r_paddr[0]), .ext_pwdata_o(r_pwdata[0]), .ext_prdata_i(r_prdata[0]),
      .ext_pready_i(r_pready[0]), .ext_pslverr_i(r_pslverr[0]),
      .core_dram_psel_i(m_psel[2]), .core_dram_penable_i(m_penable[2]),
      .core_dram_pwrite_i(m_pwrite[2]), .core_dram_paddr_i(m_paddr[2]),
      .core_dram_pwdata_i(m_pwdata[2]), .core_dram_prdata_o(s_prdata[2]),
      .core_dram_pready_o(s_pready[2]), .core_dram_pslverr_o(s_pslverr[2]),
      .dram_psel_o(r_psel[1]), .dram_penable_o(r_penable[1]), .dram_pwrite_o(r_pwrite[1]),
      .dram_paddr_o(r_paddr[1]), .dram_pwdata_o(r_pwdata[1]), .dram_prdata_i(r_prdata[1]),
      .dram_pready_i(r_pready[1]), .dram_pslverr_i(r_pslverr[1]),
      .core_rst_n_o(core_rst_n)
   );

   bind zynq_shell_top zynq_shell_props u_props (
      .aclk_i(aclk_i),
      .rst_n_i(rst_n_i),
      .core_rst_n_i(core_rst_n_o),
      .psel_i({host_psel_i, core_io_psel_i, core_dram_psel_i, ext_psel_o, dram_psel_o}),
      .penable_i({host_penable_i, core_io_penable_i, core_dram_penable_i,
                  ext_penable_o, dram_penable_o}),
      .pready_i({host_pready_o, core_io_pready_o, core_dram_pready_o,
                 ext_pready_i, dram_pready_i}),
      .ctl_i({{host_pwrite_i, 26'd0, host_paddr_i, host_pwdata_i},
              {core_io_pwrite_i, core_io_paddr_i, core_io_pwdata_i},
              {core_dram_pwrite_i, core_dram_paddr_i, core_dram_pwdata_i},
              {ext_pwrite_o, ext_paddr_o, ext_pwdata_o},
              {dram_pwrite_o, dram_paddr_o, dram_pwdata_o}})
   );

   initial
   begin
      aclk = 1'b0;
      forever #20 aclk = ~aclk;
   end

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step for every bit taken
   function automatic shell_data_t next_random(input int nbits);
      shell_data_t value;
      logic        fb;
      int          i;
      value = '0;
      for (i = 0; i < nbits; i++)
      begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         value = {value[30:0], fb};
      end
      return value;
   endfunction

   // word-aligned core I/O address inside the mailbox region
   function automatic shell_addr_t mbox_addr();
      return {11'd0, 19'(next_random(19)), 2'b00};
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic end_test(input string name, input int start);
      $display("test %s finished with %0d errors", name, errors - start);
   endtask

   task automatic apb_xfer(input int bus, input logic wr, input shell_addr_t addr,
                           input shell_data_t wdata, output shell_data_t rdata,
                           output logic err);
      int cycles;
      @(negedge aclk);
      m_psel[bus] = 1'b1;
      m_penable[bus] = 1'b0;
      m_pwrite[bus] = wr;
      m_paddr[bus] = addr;
      m_pwdata[bus] = wdata;
      @(negedge aclk);
      m_penable[bus] = 1'b1;
      cycles = 0;
      @(posedge aclk);
      while (!s_pready[bus] && cycles < timeout_lp)
      begin
         cycles++;
         @(posedge aclk);
      end
      if (!s_pready[bus])
      begin
         $display("timeout: bus %0d never raised pready at %0t ns", bus, $time);
         errors++;
      end
      rdata = s_prdata[bus];
      err = s_pslverr[bus];
      @(negedge aclk);
      m_psel[bus] = 1'b0;
      m_penable[bus] = 1'b0;
   endtask

   // answers one transfer after the given number of wait states
   task automatic respond(input int port, input int waits, input shell_data_t rdata,
                          input logic err, output shell_addr_t addr,
                          output shell_data_t wdata, output logic wr, output logic en);
      int cycles;
      cycles = 0;
      @(posedge aclk);
      while (!(r_psel[port] && !r_penable[port]) && cycles < timeout_lp)
      begin
         cycles++;
         @(posedge aclk);
      end
      if (!(r_psel[port] && !r_penable[port]))
      begin
         $display("timeout: responder %0d never saw a setup phase at %0t ns", port, $time);
         errors++;
      end
      addr = r_paddr[port];
      wdata = r_pwdata[port];
      wr = r_pwrite[port];
      repeat (waits + 1) @(negedge aclk);
      r_pready[port] = 1'b1;
      r_prdata[port] = rdata;
      r_pslverr[port] = err;
      // the completing edge must fall in the access phase
      @(posedge aclk);
      en = r_penable[port];
      @(negedge aclk);
      r_pready[port] = 1'b0;
      r_prdata[port] = '0;
      r_pslverr[port] = 1'b0;
   endtask

   task automatic host_write(input logic [5:0] addr, input shell_data_t data,
                             input logic exp_err);
      shell_data_t rdata;
      logic        err;
      apb_xfer(host_bus_lp, 1'b1, 32'(addr), data, rdata, err);
      check("host_pslverr_o", err, exp_err);
   endtask

   task automatic host_read(input logic [5:0] addr, input shell_data_t exp_data,
                            input logic exp_err);
      shell_data_t rdata;
      logic        err;
      apb_xfer(host_bus_lp, 1'b0, 32'(addr), '0, rdata, err);
      check("host_prdata_o", rdata, exp_data);
      check("host_pslverr_o", err, exp_err);
   endtask

   // one transfer through the shell to a responder, direction and data random
   task automatic routed_access(input int bus, input int port, input string core_name,
                                input string far_name, input shell_addr_t addr,
                                input shell_addr_t exp_addr, input int waits);
      logic        wr;
      shell_data_t wdata;
      shell_data_t rsp_data;
      logic        rsp_err;
      shell_data_t got_data;
      logic        got_err;
      shell_addr_t seen_addr;
      shell_data_t seen_wdata;
      logic        seen_wr;
      logic        seen_en;
      wr = (next_random(1) != 0);
      wdata = next_random(32);
      rsp_data = next_random(32);
      rsp_err = (next_random(1) != 0);
      fork
         apb_xfer(bus, wr, addr, wdata, got_data, got_err);
         respond(port, waits, rsp_data, rsp_err, seen_addr, seen_wdata, seen_wr, seen_en);
      join
      check({far_name, "_paddr_o"}, seen_addr, exp_addr);
      check({far_name, "_pwrite_o"}, seen_wr, wr);
      check({far_name, "_penable_o"}, seen_en, 1'b1);
      if (wr)
      begin
         check({far_name, "_pwdata_o"}, seen_wdata, wdata);
      end
      else
      begin
         check({core_name, "_prdata_o"}, got_data, rsp_data);
      end
      check({core_name, "_pslverr_o"}, got_err, rsp_err);
   endtask

   task automatic test_control_regs();
      int          start;
      shell_data_t val;
      start = errors;
      check("core_rst_n_o", core_rst_n, 1'b0);
      host_read(`CSR_RUN, '0, 1'b0);
      host_read(`CSR_ALLOC, '0, 1'b0);
      host_read(`CSR_DRAM_BASE, '0, 1'b0);
      val = next_random(32);
      host_write(`CSR_ALLOC, val, 1'b0);
      host_read(`CSR_ALLOC, {31'd0, val[0]}, 1'b0);
      host_write(`CSR_ALLOC, ~val, 1'b0);
      host_read(`CSR_ALLOC, {31'd0, ~val[0]}, 1'b0);
      cur_base = next_random(32);
      host_write(`CSR_DRAM_BASE, cur_base, 1'b0);
      host_read(`CSR_DRAM_BASE, cur_base, 1'b0);
      host_write(`CSR_RUN, 32'd1, 1'b0);
      host_read(`CSR_RUN, 32'd1, 1'b0);
      check("core_rst_n_o", core_rst_n, 1'b1);
      host_write(`CSR_PROFILE0, next_random(32), 1'b1);
      host_write(`CSR_MBOX_COUNT, next_random(32), 1'b1);
      host_read(`CSR_PROFILE0, '0, 1'b0);
      end_test("control registers", start);
   endtask

   task automatic test_mailbox();
      int          start;
      int          i;
      shell_data_t q[$];
      shell_data_t wdata;
      shell_data_t rdata;
      logic        err;
      logic        stall_done;
      start = errors;
      for (i = 0; i < 3; i++)
      begin
         wdata = next_random(32);
         q.push_back(wdata);
         apb_xfer(io_bus_lp, 1'b1, mbox_addr(), wdata, rdata, err);
         check("core_io_pslverr_o", err, 1'b0);
      end
      host_read(`CSR_MBOX_COUNT, 32'd3, 1'b0);
      for (i = 0; i < 3; i++)
      begin
         host_read(`CSR_MBOX_DATA, q.pop_front(), 1'b0);
      end
      // four entries fill the FIFO, so the fifth write waits for a pop
      for (i = 0; i < 5; i++)
      begin
         wdata = next_random(32);
         q.push_back(wdata);
         if (i < 4)
         begin
            apb_xfer(io_bus_lp, 1'b1, mbox_addr(), wdata, rdata, err);
            check("core_io_pslverr_o", err, 1'b0);
         end
      end
      stall_done = 1'b0;
      fork
         begin
            apb_xfer(io_bus_lp, 1'b1, mbox_addr(), wdata, rdata, err);
            stall_done = 1'b1;
         end
         begin
            repeat (6) @(negedge aclk);
            check("core_io_pready_o while full", stall_done, 1'b0);
            host_read(`CSR_MBOX_DATA, q.pop_front(), 1'b0);
         end
      join
      check("core_io_pslverr_o", err, 1'b0);
      host_read(`CSR_MBOX_COUNT, 32'd4, 1'b0);
      for (i = 0; i < 4; i++)
      begin
         host_read(`CSR_MBOX_DATA, q.pop_front(), 1'b0);
      end
      host_read(`CSR_MBOX_DATA, '0, 1'b1);
      apb_xfer(io_bus_lp, 1'b0, mbox_addr(), '0, rdata, err);
      check("core_io_prdata_o", rdata, '0);
      check("core_io_pslverr_o", err, 1'b1);
      end_test("mailbox", start);
   endtask

   task automatic test_router();
      int          start;
      int          i;
      shell_addr_t addr;
      start = errors;
      for (i = 0; i < 6; i++)
      begin
         addr = next_random(32);
         if (i == 0)
         begin
            addr = `SHELL_SPLIT_ADDR;
         end
         else if (addr < `SHELL_SPLIT_ADDR)
         begin
            addr = addr + `SHELL_SPLIT_ADDR;
         end
         routed_access(io_bus_lp, ext_port_lp, "core_io", "ext", addr, addr, i % 3);
      end
      end_test("router", start);
   endtask

   task automatic test_dram_remap();
      int          start;
      int          i;
      shell_addr_t addr;
      start = errors;
      for (i = 0; i < 6; i++)
      begin
         cur_base = next_random(32);
         host_write(`CSR_DRAM_BASE, cur_base, 1'b0);
         addr = next_random(32);
         routed_access(dram_bus_lp, mem_port_lp, "core_dram", "dram", addr,
                       (addr ^ 32'h8000_0000) + cur_base, i % 3);
      end
      end_test("dram remap", start);
   endtask

   task automatic test_profiler();
      int           start;
      int           i;
      shell_addr_t  addr;
      logic [127:0] exp_map;
      start = errors;
      // a pass through core reset starts from an empty bitmap
      host_write(`CSR_RUN, 32'd0, 1'b0);
      host_write(`CSR_RUN, 32'd1, 1'b0);
      exp_map = '0;
      for (i = 0; i < 8; i++)
      begin
         addr = 32'h8000_0000 | next_random(30);
         exp_map[addr[29:23]] = 1'b1;
         routed_access(dram_bus_lp, mem_port_lp, "core_dram", "dram", addr,
                       (addr ^ 32'h8000_0000) + cur_base, 0);
      end
      for (i = 0; i < 4; i++)
      begin
         host_read(6'(`CSR_PROFILE0 + 4 * i), exp_map[32 * i +: 32], 1'b0);
      end
      host_write(`CSR_RUN, 32'd0, 1'b0);
      host_write(`CSR_RUN, 32'd1, 1'b0);
      for (i = 0; i < 4; i++)
      begin
         host_read(6'(`CSR_PROFILE0 + 4 * i), '0, 1'b0);
      end
      end_test("profiler", start);
   endtask

   initial
   begin
      lfsr_state = 32'haf5a40d3;
      cur_base = '0;
      errors = 0;
      checks = 0;
      rst_n = 1'b0;
      m_psel = '0;
      m_penable = '0;
      m_pwrite = '0;
      m_paddr = '0;
      m_pwdata = '0;
      r_prdata = '0;
      r_pready = '0;
      r_pslverr = '0;
      repeat (8) @(posedge aclk);
      @(negedge aclk);
      rst_n = 1'b1;
      test_control_regs();
      test_mailbox();
      test_router();
      test_dram_remap();
      test_profiler();
      errors += u_zynq_shell_top.u_props.assert_fails;
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/zynq_shell_pkg.sv
design/shell_csr.sv
design/mailbox_fifo.sv
design/mailbox_port.sv
design/core_io_router.sv
design/dram_remap.sv
design/zynq_shell_top.sv
tb/zynq_shell_props.sv
tb/zynq_shell_tb.sv

// ==== Bender.yml ====
package:
  name: zynq_shell

sources:
  - include_dirs:
      - design
    files:
      - design/zynq_shell_pkg.sv
      - design/shell_csr.sv
      - design/mailbox_fifo.sv
      - design/mailbox_port.sv
      - design/core_io_router.sv
      - design/dram_remap.sv
      - design/zynq_shell_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/zynq_shell_props.sv
      - tb/zynq_shell_tb.sv
